// ==== source/soqpskPkg.sv ====
// Struct field widths come from these constants so module width parameters must keep the same values
`default_nettype none

package soqpskPkg;

  // ******************************
  // Widths and counts
  // ******************************
  localparam int ADDR_WIDTH      = 12;  // Host word address
  localparam int HOST_DATA_WIDTH = 16;
  localparam int REG_WIDTH       = 32;  // Internal registers, read as two halves
  localparam int SAMPLE_WIDTH    = 18;  // Demod and trellis sample streams
  localparam int DAC_WIDTH       = 14;
  localparam int NUM_DAC         = 3;

  // ******************************
  // Constants
  // ******************************
  localparam logic [15:0] VER_NUMBER = 16'h0079;  // Default version code
  localparam int SOFT_RESET_CYCLES   = 6;         // Stretched DAC reset length

  // Register space, taken from address bits 11:4
  typedef enum logic [7:0] {
    SPACE_MISC = 8'h00,
    SPACE_DAC0 = 8'h10,
    SPACE_DAC1 = 8'h11,
    SPACE_DAC2 = 8'h12
  } hostSpace_t;

  // Misc register, taken from address bits 3:2
  typedef enum logic [1:0] {
    MISC_RESET   = 2'd0,
    MISC_VERSION = 2'd1,
    MISC_CLOCK   = 2'd2
  } miscReg_t;

  // DAC source codes
  // Only the four trellis codes pick the trellis stream
  typedef enum logic [3:0] {
    DAC_DEMOD         = 4'd0,
    DAC_TRELLIS_I     = 4'd8,
    DAC_TRELLIS_Q     = 4'd9,
    DAC_TRELLIS_PHERR = 4'd10,
    DAC_TRELLIS_INDEX = 4'd11
  } dacSource_t;

  // ******************************
  // Bus and stream structs
  // ******************************
  typedef struct packed {
    logic                       cs;
    logic                       we;
    logic                       re;
    logic [ADDR_WIDTH-1:0]      addr;
    logic [HOST_DATA_WIDTH-1:0] wdata;
  } hostBus_t;  // 31 bits

  typedef struct packed {
    logic                    sync;  // Sample valid
    logic [SAMPLE_WIDTH-1:0] data;
  } sample_t;

  typedef struct packed {
    logic                 sync;
    logic [DAC_WIDTH-1:0] code;  // Offset binary
  } dacOut_t;

endpackage

`default_nettype wire

// ==== source/hostDecode.sv ====
// Synchronous host bus with no wait states and reads outside the misc and DAC spaces return zero
`timescale 1ns/100ps
`default_nettype none

module hostDecode (
  input  wire                                          ck933,
  input  wire                                          clockCounterEn,
  input  soqpskPkg::hostBus_t                          bus_i,
  input  wire [soqpskPkg::REG_WIDTH-1:0]               miscRdata_i,
  input  soqpskPkg::dacSource_t                        dacSelRdata_i [soqpskPkg::NUM_DAC],
  output logic                                         miscSel_o,
  output logic [soqpskPkg::NUM_DAC-1:0]                dacSel_o,
  output logic [soqpskPkg::HOST_DATA_WIDTH-1:0]        rdata_o
);

  import soqpskPkg::*;

  hostSpace_t                 space;
  logic                       miscHit;
  logic [NUM_DAC-1:0]         dacHit;
  logic [REG_WIDTH-1:0]       selWord;
  logic [HOST_DATA_WIDTH-1:0] halfWord;

  // ******************************
  // Space decode
  // ******************************
  assign space = hostSpace_t'(bus_i.addr[ADDR_WIDTH-1:4]);

  always_comb begin
    miscHit = 1'b0;
    dacHit  = '0;
    case (space)
      SPACE_MISC: miscHit   = 1'b1;
      SPACE_DAC0: dacHit[0] = 1'b1;
      SPACE_DAC1: dacHit[1] = 1'b1;
      SPACE_DAC2: dacHit[2] = 1'b1;
      default: ;  // Unmapped
    endcase
  end

  assign miscSel_o = bus_i.cs & miscHit;
  assign dacSel_o  = bus_i.cs ? dacHit : '0;

  // ******************************
  // Read back
  // ******************************
  always_comb begin
    selWord = '0;
    if (miscHit) begin
      selWord = miscRdata_i;
    end
    for (int i = 0; i < NUM_DAC; i++) begin
      if (dacHit[i]) begin
        selWord = REG_WIDTH'(dacSelRdata_i[i]);  // Source code in the low bits
      end
    end
  end

  // Address bit 1 picks the upper half
  assign halfWord = bus_i.addr[1] ? selWord[REG_WIDTH-1:HOST_DATA_WIDTH]
                                  : selWord[HOST_DATA_WIDTH-1:0];

  // Held until the next read
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      rdata_o <= '0;
    end else if (bus_i.cs && bus_i.re) begin
      rdata_o <= halfWord;
    end
  end

  // A read outside every space loads zero
  unmappedZero: assert property (
    @(posedge ck933) disable iff (clockCounterEn)
      bus_i.cs && bus_i.re && !miscSel_o && (dacSel_o == '0) |=> rdata_o == '0
  ) else $error("hostDecode unmapped read not zero");

endmodule

`default_nettype wire

// ==== source/miscRegs.sv ====
// Clock count reads return the live count at the read edge and a reset write during a pulse restarts it
`timescale 1ns/100ps
`default_nettype none

module miscRegs #(
  parameter logic [15:0] VER_NUMBER = soqpskPkg::VER_NUMBER
) (
  input  wire                            ck933,
  input  wire                            clockCounterEn,
  input  soqpskPkg::hostBus_t            bus_i,
  input  wire                            miscSel_i,
  output logic [soqpskPkg::REG_WIDTH-1:0] miscRdata_o,
  output logic                           dacRst_o
);

  import soqpskPkg::*;

  localparam int RST_CNT_WIDTH = $clog2(SOFT_RESET_CYCLES);

  miscReg_t                 regSel;
  logic                     wrStrobe;
  logic [REG_WIDTH-1:0]     clockCounter;
  logic                     rstPending;
  logic [RST_CNT_WIDTH-1:0] rstCount;

  assign regSel    = miscReg_t'(bus_i.addr[3:2]);
  assign wrStrobe  = miscSel_i & bus_i.we;

  // ******************************
  // Cycle measurement
  // ******************************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      clockCounter <= '0;
    end else if (wrStrobe && regSel == MISC_CLOCK) begin
      clockCounter <= '0;  // Restart measurement
    end else begin
      clockCounter <= clockCounter + 1'b1;
    end
  end

  always_comb begin
    case (regSel)
      MISC_VERSION: miscRdata_o = {VER_NUMBER, HOST_DATA_WIDTH'(0)};
      MISC_CLOCK:   miscRdata_o = clockCounter;
      default:      miscRdata_o = '0;  // Reset register reads as zero
    endcase
  end

  // ******************************
  // Software reset stretcher
  // ******************************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      rstPending <= 1'b0;
      rstCount   <= '0;
      dacRst_o   <= 1'b0;
    end else begin
      rstPending <= wrStrobe && (regSel == MISC_RESET);
      if (rstPending) begin
        rstCount <= RST_CNT_WIDTH'(SOFT_RESET_CYCLES - 1);
        dacRst_o <= 1'b1;
      end else if (rstCount != '0) begin
        rstCount <= rstCount - 1'b1;  // Pulse still running
      end else begin
        dacRst_o <= 1'b0;
      end
    end
  end

  // A pulse that is not restarted lasts exactly SOFT_RESET_CYCLES
  rstLength: assert property (
    @(posedge ck933) disable iff (clockCounterEn || rstPending)
      $rose(dacRst_o) |-> dacRst_o [*SOFT_RESET_CYCLES] ##1 !dacRst_o
  ) else $error("miscRegs dacRst_o pulse length wrong");

endmodule

`default_nettype wire

// ==== source/dacChannel.sv ====
// Width parameters must match the package struct widths and codes only update on a valid sample
`timescale 1ns/100ps
`default_nettype none

module dacChannel #(
  parameter int SAMPLE_WIDTH = soqpskPkg::SAMPLE_WIDTH,
  parameter int DAC_WIDTH    = soqpskPkg::DAC_WIDTH
) (
  input  wire                   ck933,
  input  wire                   clockCounterEn,
  input  wire                   softRst_i,
  input  soqpskPkg::hostBus_t   bus_i,
  input  wire                   chSel_i,
  input  soqpskPkg::sample_t    demod_i,
  input  soqpskPkg::sample_t    trellis_i,
  output soqpskPkg::dacSource_t srcSel_o,
  output soqpskPkg::dacOut_t    dac_o
);

  import soqpskPkg::*;

  localparam int SRC_WIDTH = $bits(dacSource_t);

  logic                    useTrellis;
  logic                    inSync;
  logic [SAMPLE_WIDTH-1:0] inData;
  logic                    selSync;
  logic [SAMPLE_WIDTH-1:0] selData;
  logic [DAC_WIDTH-1:0]    offsetCode;
  logic                    rstBlock;

  function automatic logic isTrellis(dacSource_t src);
    case (src)
      DAC_TRELLIS_I, DAC_TRELLIS_Q, DAC_TRELLIS_PHERR, DAC_TRELLIS_INDEX: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // ******************************
  // Source select register
  // ******************************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      srcSel_o <= DAC_DEMOD;
    end else if (softRst_i) begin
      srcSel_o <= DAC_DEMOD;  // Held for the whole pulse
    end else if (chSel_i && bus_i.we) begin
      srcSel_o <= dacSource_t'(bus_i.wdata[SRC_WIDTH-1:0]);
    end
  end

  // ******************************
  // Sample mux, cycle 1
  // ******************************
  assign useTrellis = isTrellis(srcSel_o);
  assign inSync     = useTrellis ? trellis_i.sync : demod_i.sync;
  assign inData     = useTrellis ? trellis_i.data : demod_i.data;

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      selSync <= 1'b0;
    end else begin
      selSync <= inSync & ~softRst_i;
    end
  end

  always_ff @(posedge ck933) begin
    selData <= inData;
  end

  // ******************************
  // Formatter, cycle 2
  // ******************************
  // Top bits with the sign flipped give offset binary
  assign offsetCode = {~selData[SAMPLE_WIDTH-1], selData[SAMPLE_WIDTH-2 -: DAC_WIDTH-1]};

  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      dac_o <= '0;
    end else if (softRst_i) begin
      dac_o <= '0;
    end else begin
      dac_o.sync <= selSync;
      if (selSync) begin
        dac_o.code <= offsetCode;  // Hold last code between samples
      end
    end
  end

  assign rstBlock = clockCounterEn | softRst_i;

  // Output sync trails the selected input sync by two edges
  syncLatency: assert property (
    @(posedge ck933) disable iff (clockCounterEn)
      !$past(rstBlock) && !$past(rstBlock, 2) |-> dac_o.sync == $past(inSync, 2)
  ) else $error("dacChannel output sync out of step");

endmodule

`default_nettype wire

// ==== source/soqpskTop.sv ====
// Demodulator and trellis streams arrive as inputs and the host bus is sampled on ck933
`timescale 1ns/100ps
`default_nettype none

module soqpskTop #(
  parameter logic [15:0] VER_NUMBER   = soqpskPkg::VER_NUMBER,
  parameter int          SAMPLE_WIDTH = soqpskPkg::SAMPLE_WIDTH,
  parameter int          DAC_WIDTH    = soqpskPkg::DAC_WIDTH
) (
  input  wire                                   ck933,
  input  wire                                   clockCounterEn,
  input  soqpskPkg::hostBus_t                   bus_i,
  input  soqpskPkg::sample_t                    demodSample_i   [soqpskPkg::NUM_DAC],
  input  soqpskPkg::sample_t                    trellisSample_i [soqpskPkg::NUM_DAC],
  output wire [soqpskPkg::HOST_DATA_WIDTH-1:0]  rdata_o,
  output soqpskPkg::dacOut_t                    dacCode_o       [soqpskPkg::NUM_DAC],
  output wire                                   dacRst_o
);

  import soqpskPkg::*;

  wire                 miscSel;
  wire [NUM_DAC-1:0]   dacSel;
  wire [REG_WIDTH-1:0] miscRdata;
  dacSource_t          dacSrc [NUM_DAC];

  // ******************************
  // Host control plane
  // ******************************
  hostDecode u_hostDecode (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .bus_i          (bus_i),
    .miscRdata_i    (miscRdata),
    .dacSelRdata_i  (dacSrc),
    .miscSel_o      (miscSel),
    .dacSel_o       (dacSel),
    .rdata_o        (rdata_o)
  );

  miscRegs #(
    .VER_NUMBER (VER_NUMBER)
  ) u_miscRegs (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .bus_i          (bus_i),
    .miscSel_i      (miscSel),
    .miscRdata_o    (miscRdata),
    .dacRst_o       (dacRst_o)  // Also clears the channels
  );

  // ******************************
  // DAC output path
  // ******************************
  dacChannel #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH),
    .DAC_WIDTH    (DAC_WIDTH)
  ) u_dacChannel0 (
    .ck933 (ck933), .clockCounterEn (clockCounterEn), .softRst_i (dacRst_o),
    .bus_i (bus_i), .chSel_i (dacSel[0]),
    .demod_i (demodSample_i[0]), .trellis_i (trellisSample_i[0]),
    .srcSel_o (dacSrc[0]), .dac_o (dacCode_o[0])
  );

  dacChannel #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH),
    .DAC_WIDTH    (DAC_WIDTH)
  ) u_dacChannel1 (
    .ck933 (ck933), .clockCounterEn (clockCounterEn), .softRst_i (dacRst_o),
    .bus_i (bus_i), .chSel_i (dacSel[1]),
    .demod_i (demodSample_i[1]), .trellis_i (trellisSample_i[1]),
    .srcSel_o (dacSrc[1]), .dac_o (dacCode_o[1])
  );

  dacChannel #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH),
    .DAC_WIDTH    (DAC_WIDTH)
  ) u_dacChannel2 (
    .ck933 (ck933), .clockCounterEn (clockCounterEn), .softRst_i (dacRst_o),
    .bus_i (bus_i), .chSel_i (dacSel[2]),
    .demod_i (demodSample_i[2]), .trellis_i (trellisSample_i[2]),
    .srcSel_o (dacSrc[2]), .dac_o (dacCode_o[2])
  );

endmodule

`default_nettype wire

// ==== test/tbChecks.svh ====
// Included inside tbSoqpskTop after its bus, clock, read data and error counters are declared
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ******************************
// Compare tasks
// ******************************
task automatic checkRdata(input string testName, input logic [HOST_DATA_WIDTH-1:0] expVal,
                          input logic [HOST_DATA_WIDTH-1:0] actVal);
  if (actVal !== expVal) begin
    $display("ERR %s expected %h actual %h", testName, expVal, actVal);
    rdataErrors++;
  end
endtask

task automatic checkDac(input string testName, input dacOut_t expVal, input dacOut_t actVal);
  if (actVal !== expVal) begin
    $display("ERR %s expected sync %b code %h actual sync %b code %h", testName,
             expVal.sync, expVal.code, actVal.sync, actVal.code);
    dacErrors++;
  end
endtask

task automatic checkRst(input string testName, input logic expVal, input logic actVal);
  if (actVal !== expVal) begin
    $display("ERR %s expected %b actual %b", testName, expVal, actVal);
    rstErrors++;
  end
endtask

// ******************************
// Host bus access
// ******************************
task automatic hostWrite(input logic [ADDR_WIDTH-1:0] addr,
                         input logic [HOST_DATA_WIDTH-1:0] data);
  @(negedge ck933);
  bus.cs    = 1'b1;
  bus.we    = 1'b1;
  bus.addr  = addr;
  bus.wdata = data;
  @(negedge ck933);  // Write edge has passed
  bus = '0;
endtask

task automatic hostRead(input logic [ADDR_WIDTH-1:0] addr,
                        output logic [HOST_DATA_WIDTH-1:0] data);
  @(negedge ck933);
  bus.cs   = 1'b1;
  bus.re   = 1'b1;
  bus.addr = addr;
  @(negedge ck933);
  bus  = '0;
  data = rdata;  // Registered at the read edge
endtask

`endif

// ==== test/tbSoqpskTop.sv ====
// Runs the DUT with its default VER_NUMBER and ends with a timeout after MAX_CYCLES clocks
`timescale 1ns/100ps
`default_nettype none

module tbSoqpskTop;

  import soqpskPkg::*;

  localparam int MAX_CYCLES        = 4000;  // Tests take under 2000 cycles
  localparam int SAMPLES_PER_ROUND = 50;    // Four rounds give 200 samples
  localparam logic [ADDR_WIDTH-1:0] ADDR_RESET      = 12'h000;
  localparam logic [ADDR_WIDTH-1:0] ADDR_VERSION_LO = 12'h004;
  localparam logic [ADDR_WIDTH-1:0] ADDR_VERSION_HI = 12'h006;
  localparam logic [ADDR_WIDTH-1:0] ADDR_CLOCK_LO   = 12'h008;
  localparam logic [ADDR_WIDTH-1:0] ADDR_CLOCK_HI   = 12'h00A;
  localparam logic [ADDR_WIDTH-1:0] ADDR_UNMAPPED   = 12'h3F0;
  localparam logic [3:0] SRC_CODES [8] = '{4'd0, 4'd8, 4'd9, 4'd10, 4'd11, 4'd3, 4'd15, 4'd1};

  logic                       ck933;
  logic                       clockCounterEn;
  hostBus_t                   bus;
  sample_t                    demodSample   [NUM_DAC];
  sample_t                    trellisSample [NUM_DAC];
  logic [HOST_DATA_WIDTH-1:0] rdata;
  dacOut_t                    dacCode [NUM_DAC];
  logic                       dacRst;

  dacSource_t                 tbSrc [NUM_DAC];     // Source each channel should hold
  logic [DAC_WIDTH-1:0]       heldCode [NUM_DAC];
  dacOut_t                    expQ [NUM_DAC][$];   // Two samples in flight
  logic                       stimOn;
  logic                       compareOn;
  integer                     seed;
  int                         cycleCount;
  int                         rdataErrors;
  int                         dacErrors;
  int                         rstErrors;
  int                         errorCount;

  `include "tbChecks.svh"

  soqpskTop u_soqpskTop (
    .ck933           (ck933),
    .clockCounterEn  (clockCounterEn),
    .bus_i           (bus),
    .demodSample_i   (demodSample),
    .trellisSample_i (trellisSample),
    .rdata_o         (rdata),
    .dacCode_o       (dacCode),
    .dacRst_o        (dacRst)
  );

  initial begin
    ck933 = 1'b0;
    forever #50 ck933 = ~ck933;
  end

  // ******************************
  // Reference model
  // ******************************
  function automatic logic usesTrellis(dacSource_t src);
    return src inside {DAC_TRELLIS_I, DAC_TRELLIS_Q, DAC_TRELLIS_PHERR, DAC_TRELLIS_INDEX};
  endfunction

  function automatic logic [DAC_WIDTH-1:0] expectedCode(sample_t demod, sample_t trellis,
                                                        dacSource_t src);
    sample_t pick;
    pick = usesTrellis(src) ? trellis : demod;
    // Flipping the MSB turns two's complement into offset binary
    return pick.data[SAMPLE_WIDTH-1 -: DAC_WIDTH] ^ {1'b1, {(DAC_WIDTH-1){1'b0}}};
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] dacAddr(int ch);
    return {SPACE_DAC0 + 8'(ch), 4'h0};  // Channel spaces are consecutive
  endfunction

  task automatic setSource(int ch, dacSource_t src);
    hostWrite(dacAddr(ch), HOST_DATA_WIDTH'(src));
    tbSrc[ch] = src;  // Used from the edge after the write
  endtask

  // Write edge E, read edge E+n
  task automatic measureClock(int n, logic upper);
    logic [HOST_DATA_WIDTH-1:0] data;
    logic [REG_WIDTH-1:0]       expCount;
    expCount = REG_WIDTH'(n - 1);
    hostWrite(ADDR_CLOCK_LO, '0);
    repeat (n - 2) @(negedge ck933);
    hostRead(upper ? ADDR_CLOCK_HI : ADDR_CLOCK_LO, data);
    checkRdata($sformatf("clock%0d%s", n, upper ? "Hi" : "Lo"),
               upper ? expCount[31:16] : expCount[15:0], data);
  endtask

  // ******************************
  // Sample stimulus and compare
  // ******************************
  initial begin : driveSamples
    logic [31:0] rnd;
    seed = 32'hf166;
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      demodSample[ch]   = '0;
      trellisSample[ch] = '0;
    end
    forever begin
      @(negedge ck933);
      for (int ch = 0; ch < NUM_DAC; ch++) begin
        rnd = $random(seed);
        demodSample[ch] = stimOn ? {rnd[31], rnd[SAMPLE_WIDTH-1:0]} : '0;
        rnd = $random(seed);
        trellisSample[ch] = stimOn ? {rnd[31], rnd[SAMPLE_WIDTH-1:0]} : '0;
      end
    end
  end

  initial begin : compareOutputs
    dacOut_t expOut;
    forever begin
      @(posedge ck933);  // Inputs stable here
      for (int ch = 0; ch < NUM_DAC; ch++) begin
        if (compareOn) begin
          expOut.sync = usesTrellis(tbSrc[ch]) ? trellisSample[ch].sync : demodSample[ch].sync;
          if (expOut.sync) begin
            heldCode[ch] = expectedCode(demodSample[ch], trellisSample[ch], tbSrc[ch]);
          end
          expOut.code = heldCode[ch];
          expQ[ch].push_back(expOut);
        end else begin
          expQ[ch].delete();
        end
      end
      @(negedge ck933);
      for (int ch = 0; ch < NUM_DAC; ch++) begin
        if (expQ[ch].size() == 2) begin
          expOut = expQ[ch].pop_front();
          checkDac($sformatf("dac%0d", ch), expOut, dacCode[ch]);
        end
      end
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < MAX_CYCLES) begin
      @(posedge ck933);
      cycleCount++;
    end
    $display("Timeout, run stopped after %0d cycles", cycleCount);
    $display(">>> FAIL");
    $finish;
  end

  // ******************************
  // Test sequence
  // ******************************
  initial begin : mainSequence
    logic [HOST_DATA_WIDTH-1:0] data;
    clockCounterEn = 1'b1;
    bus            = '0;
    stimOn         = 1'b0;
    compareOn      = 1'b0;
    rdataErrors    = 0;
    dacErrors      = 0;
    rstErrors      = 0;
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      tbSrc[ch]    = DAC_DEMOD;
      heldCode[ch] = '0;
    end
    repeat (3) @(negedge ck933);
    clockCounterEn = 1'b0;

    checkRst("resetRst", 1'b0, dacRst);
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      checkDac("resetDac", '0, dacCode[ch]);
      hostRead(dacAddr(ch), data);
      checkRdata("resetSrc", HOST_DATA_WIDTH'(DAC_DEMOD), data);
    end

    hostRead(ADDR_VERSION_LO, data);
    checkRdata("versionLo", '0, data);
    hostRead(ADDR_VERSION_HI, data);
    checkRdata("versionHi", VER_NUMBER, data);
    hostRead(ADDR_UNMAPPED, data);  // After a nonzero read
    checkRdata("unmapped", '0, data);

    measureClock(10, 1'b0);
    measureClock(10, 1'b1);
    measureClock(300, 1'b0);
    measureClock(300, 1'b1);

    // Sources change while samples keep flowing
    stimOn    = 1'b1;
    compareOn = 1'b1;
    for (int round = 0; round < 4; round++) begin
      for (int ch = 0; ch < NUM_DAC; ch++) begin
        setSource(ch, dacSource_t'(SRC_CODES[3'(round * NUM_DAC + ch)]));
        hostRead(dacAddr(ch), data);
        checkRdata("srcReadback", HOST_DATA_WIDTH'(tbSrc[ch]), data);
      end
      repeat (SAMPLES_PER_ROUND) @(negedge ck933);
    end
    stimOn = 1'b0;
    repeat (3) @(negedge ck933);
    compareOn = 1'b0;

    // Software reset pulse
    hostWrite(ADDR_RESET, 16'h0001);
    checkRst("rstWriteEdge", 1'b0, dacRst);
    for (int i = 0; i < SOFT_RESET_CYCLES; i++) begin
      @(negedge ck933);
      checkRst("rstPulse", 1'b1, dacRst);
      for (int ch = 0; ch < NUM_DAC; ch++) begin
        if (i > 0) checkDac("rstDac", '0, dacCode[ch]);  // Cleared from the second cycle
      end
    end
    @(negedge ck933);
    checkRst("rstEnd", 1'b0, dacRst);
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      hostRead(dacAddr(ch), data);
      checkRdata("rstSrc", HOST_DATA_WIDTH'(DAC_DEMOD), data);
    end

    errorCount = rdataErrors + dacErrors + rstErrors;
    $display("Errors %0d total, %0d rdata, %0d dac, %0d reset",
             errorCount, rdataErrors, dacErrors, rstErrors);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+test
source/soqpskPkg.sv
source/hostDecode.sv
source/miscRegs.sv
source/dacChannel.sv
source/soqpskTop.sv
test/tbSoqpskTop.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and passes only when the pass line is printed
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tbSoqpskTop
result=$(./obj_dir/VtbSoqpskTop)
echo "$result"
if echo "$result" | grep -Fqx ">>> PASS"; then
  exit 0
else
  exit 1
fi
